// File: Makefile
TOP := tb_vec_remap

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) -o sim
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir

// File: issue_fifo.sv
// Synchronous issue queue with a generic payload type
// Circular buffer, push and pop allowed in the same cycle
`timescale 1ns/10ps
`include "vrrm_cfg.svh"

module issue_fifo #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     rstn_i,
    input  logic     push_i,
    input  payload_t data_i,
    output logic     full_o,
    input  logic     pop_i,
    output payload_t data_o,
    output logic     valid_o
);

    localparam int DEPTH = `VRRM_QDEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign valid_o = (count_q != '0);
    assign data_o  = mem_q[rd_ptr_q];

    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & valid_o;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            // Explicit wrap so the depth need not be a power of two
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    // Producer must watch full_o
    a_no_push_full: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        !(push_i && full_o)
    ) else $error("issue_fifo: push while full");

    // Consumer must only pop a valid entry
    a_no_pop_empty: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        !(pop_i && !valid_o)
    ) else $error("issue_fifo: pop while empty");

endmodule

// File: tb_clkgen.sv
// Testbench clock and reset source
// 10 ns clock, active low reset held for 8 cycles
`timescale 1ns/10ps

module tb_clkgen (
    output logic clk_o,
    output logic rstn_o
);

    localparam real HALF_PERIOD = 5.0;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    initial begin
        rstn_o = 1'b0;
        repeat (8) @(posedge clk_o);
        rstn_o <= 1'b1;
    end

endmodule

// File: tb_vec_remap.sv
// Testbench for the vector remap front end
// Vector file stimulus, random readies, in-order checks on both issue streams
`timescale 1ns/10ps

module tb_vec_remap import vrrm_pkg::*; ();

    localparam int NFIELD  = 14;
    localparam int MAX_VEC = 64;
    localparam int DRAIN   = 6;

    // Columns of the vector file
    localparam int F_OP     = 0;
    localparam int F_FUNCT  = 1;
    localparam int F_DST    = 2;
    localparam int F_SRC1   = 3;
    localparam int F_SRC2   = 4;
    localparam int F_RECONF = 5;
    localparam int F_MAXVL  = 6;
    localparam int F_DATA   = 7;
    localparam int F_EDST   = 8;
    localparam int F_ESRC1  = 9;
    localparam int F_ESRC2  = 10;
    localparam int F_ELOCK  = 11;
    localparam int F_EZERO  = 12;
    localparam int F_EMEM   = 13;

    logic            clk_i;
    logic            rstn_i;
    logic            in_valid_i;
    v_instr_t        in_instr_i;
    logic            in_pop_o;
    logic            ex_valid_o;
    remapped_instr_t ex_instr_o;
    logic            ex_ready_i;
    logic            mem_valid_o;
    mem_instr_t      mem_instr_o;
    logic            mem_ready_i;
    logic            idle_o;

    logic [31:0] vec_mem [NFIELD*MAX_VEC];
    int          n_vec;
    int          next_vec;
    int          cycles;
    int          cycle_limit;
    int          drain;
    int          errors;
    int          tests_run;
    int          tests_bad;
    int          left_cnt [MAX_VEC];
    int          bad_cnt [MAX_VEC];
    // Vector numbers still owed by each stream in arrival order
    int          ex_exp_q [$];
    int          mem_exp_q [$];

    tb_clkgen u_tb_clkgen (
        .clk_o  (clk_i),
        .rstn_o (rstn_i)
    );

    vec_remap_top u_vec_remap_top (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .in_valid_i  (in_valid_i),
        .in_instr_i  (in_instr_i),
        .in_pop_o    (in_pop_o),
        .ex_valid_o  (ex_valid_o),
        .ex_instr_o  (ex_instr_o),
        .ex_ready_i  (ex_ready_i),
        .mem_valid_o (mem_valid_o),
        .mem_instr_o (mem_instr_o),
        .mem_ready_i (mem_ready_i),
        .idle_o      (idle_o)
    );

    function automatic logic [31:0] field(input int v, input int f);
        return vec_mem[v * NFIELD + f];
    endfunction

    // Word left in place where the vector file writes nothing
    function automatic logic [31:0] fill_word(input int addr);
        return 32'hDEAD_0000 | 32'(addr);
    endfunction

    function automatic v_instr_t build_instr(input int v);
        v_instr_t ins;
        ins.op_class    = op_class_t'(field(v, F_OP));
        ins.funct       = funct_t'(field(v, F_FUNCT));
        ins.dst         = vreg_idx_t'(field(v, F_DST));
        ins.src1        = vreg_idx_t'(field(v, F_SRC1));
        ins.src2        = vreg_idx_t'(field(v, F_SRC2));
        ins.reconfigure = (field(v, F_RECONF) != 0);
        ins.maxvl       = maxvl_t'(field(v, F_MAXVL));
        ins.data1       = data_t'(field(v, F_DATA));
        return ins;
    endfunction

    task automatic check_value(input int v, input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        if (exp !== got) begin
            $display("MISMATCH t=%0t %s (vector %0d) expected %0h got %0h",
                     $time, name, v, exp, got);
            errors++;
            bad_cnt[v]++;
        end
    endtask

    // A vector is finished once every stream it goes to has delivered it
    task automatic count_delivery(input int v);
        left_cnt[v]--;
        if (left_cnt[v] == 0) begin
            tests_run++;
            if (bad_cnt[v] != 0) begin
                tests_bad++;
                $display("vector %0d: FAILED with %0d wrong fields", v, bad_cnt[v]);
            end else begin
                $display("vector %0d: ok", v);
            end
        end
    endtask

    task automatic check_ex_entry();
        int v;
        if (ex_exp_q.size() == 0) begin
            $display("ERROR t=%0t execute stream delivered an entry nobody sent", $time);
            errors++;
        end else begin
            v = ex_exp_q.pop_front();
            check_value(v, "ex_instr_o.dst", field(v, F_EDST), 32'(ex_instr_o.dst));
            check_value(v, "ex_instr_o.src1", field(v, F_ESRC1), 32'(ex_instr_o.src1));
            check_value(v, "ex_instr_o.src2", field(v, F_ESRC2), 32'(ex_instr_o.src2));
            check_value(v, "ex_instr_o.lock", field(v, F_ELOCK), 32'(ex_instr_o.lock));
            check_value(v, "ex_instr_o.dst_iszero", field(v, F_EZERO),
                        32'(ex_instr_o.dst_iszero));
            check_value(v, "ex_instr_o.op_class", field(v, F_OP), 32'(ex_instr_o.op_class));
            check_value(v, "ex_instr_o.funct", field(v, F_FUNCT), 32'(ex_instr_o.funct));
            check_value(v, "ex_instr_o.reconfigure", field(v, F_RECONF),
                        32'(ex_instr_o.reconfigure));
            check_value(v, "ex_instr_o.maxvl", field(v, F_MAXVL), 32'(ex_instr_o.maxvl));
            check_value(v, "ex_instr_o.data1", field(v, F_DATA), ex_instr_o.data1);
            count_delivery(v);
        end
    endtask

    task automatic check_mem_entry();
        int v;
        if (mem_exp_q.size() == 0) begin
            $display("ERROR t=%0t memory stream delivered an entry nobody sent", $time);
            errors++;
        end else begin
            v = mem_exp_q.pop_front();
            check_value(v, "mem_instr_o.dst", field(v, F_EDST), 32'(mem_instr_o.dst));
            check_value(v, "mem_instr_o.src1", field(v, F_ESRC1), 32'(mem_instr_o.src1));
            check_value(v, "mem_instr_o.src2", field(v, F_ESRC2), 32'(mem_instr_o.src2));
            check_value(v, "mem_instr_o.op_class", field(v, F_OP), 32'(mem_instr_o.op_class));
            check_value(v, "mem_instr_o.reconfigure", field(v, F_RECONF),
                        32'(mem_instr_o.reconfigure));
            check_value(v, "mem_instr_o.maxvl", field(v, F_MAXVL), 32'(mem_instr_o.maxvl));
            check_value(v, "mem_instr_o.data1", field(v, F_DATA), mem_instr_o.data1);
            count_delivery(v);
        end
    endtask

    initial begin
        for (int i = 0; i < NFIELD * MAX_VEC; i++) begin
            vec_mem[i] = fill_word(i);
        end
        void'($urandom(58059));
        $readmemh("vec_remap_vectors.txt", vec_mem);
        n_vec = 0;
        // Unwritten rows still hold their fill word
        while (n_vec < MAX_VEC && vec_mem[n_vec * NFIELD] != fill_word(n_vec * NFIELD)) begin
            n_vec++;
        end
        for (int v = 0; v < MAX_VEC; v++) begin
            left_cnt[v] = (field(v, F_EMEM) == 32'd1) ? 2 : 1;
            bad_cnt[v]  = 0;
        end
        if (n_vec == 0) begin
            $display("ERROR no vectors could be read from vec_remap_vectors.txt");
        end
        cycle_limit = 20 * n_vec + 200;
        in_valid_i  = 1'b0;
        in_instr_i  = '0;
        ex_ready_i  = 1'b0;
        mem_ready_i = 1'b0;
    end

    always @(posedge clk_i) begin
        if (rstn_i) begin
            cycles++;
            if (cycles == 1) begin
                tests_run++;
                if (!idle_o || ex_valid_o || mem_valid_o) begin
                    tests_bad++;
                    errors++;
                    $display("reset check: FAILED, not idle or a stream is valid");
                end else begin
                    $display("reset check: ok");
                end
            end
            if (ex_valid_o && ex_ready_i) begin
                check_ex_entry();
            end
            if (mem_valid_o && mem_ready_i) begin
                check_mem_entry();
            end
            // The stage took the vector presented before this edge
            if (in_valid_i && in_pop_o) begin
                ex_exp_q.push_back(next_vec);
                if (field(next_vec, F_EMEM) == 32'd1) begin
                    mem_exp_q.push_back(next_vec);
                end
                next_vec++;
            end
            if (next_vec < n_vec) begin
                in_valid_i <= 1'b1;
                in_instr_i <= build_instr(next_vec);
            end else begin
                in_valid_i <= 1'b0;
            end
            ex_ready_i  <= ($urandom % 2) != 0;
            mem_ready_i <= ($urandom % 2) != 0;
            if (next_vec == n_vec && ex_exp_q.size() == 0 && mem_exp_q.size() == 0) begin
                drain++;
            end
            if (drain == DRAIN) begin
                if (ex_valid_o || mem_valid_o || !idle_o) begin
                    $display("ERROR t=%0t entries remain queued after the last vector", $time);
                    errors++;
                end
                $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_bad,
                         errors);
                if (errors == 0 && n_vec > 0) begin
                    $display("TEST PASS");
                end else begin
                    $display("TEST FAIL");
                end
                $finish;
            end else if (cycles >= cycle_limit) begin
                $display("ERROR timeout after %0d cycles, %0d of %0d vectors accepted",
                         cycles, next_vec, n_vec);
                $display("TEST FAIL");
                $finish;
            end
        end
    end

endmodule

// File: vec_remap_top.sv
// Top level of the vector remap front end
// Remap stage feeding the execute and memory issue queues
`timescale 1ns/10ps

module vec_remap_top import vrrm_pkg::*; (
    input  logic            clk_i,
    input  logic            rstn_i,
    // Instruction queue side
    input  logic            in_valid_i,
    input  v_instr_t        in_instr_i,
    output logic            in_pop_o,
    // Execute stream
    output logic            ex_valid_o,
    output remapped_instr_t ex_instr_o,
    input  logic            ex_ready_i,
    // Memory stream
    output logic            mem_valid_o,
    output mem_instr_t      mem_instr_o,
    input  logic            mem_ready_i,
    output logic            idle_o
);

    logic            ex_full;
    logic            ex_push;
    remapped_instr_t ex_instr_d;
    logic            mem_full;
    logic            mem_push;
    mem_instr_t      mem_instr_d;

    vrrm u_vrrm (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .in_valid_i  (in_valid_i),
        .in_instr_i  (in_instr_i),
        .in_pop_o    (in_pop_o),
        .ex_full_i   (ex_full),
        .ex_push_o   (ex_push),
        .ex_instr_o  (ex_instr_d),
        .mem_full_i  (mem_full),
        .mem_push_o  (mem_push),
        .mem_instr_o (mem_instr_d)
    );

    // A ready without a valid entry is not a pop
    issue_fifo #(.payload_t(remapped_instr_t)) u_ex_fifo (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .push_i  (ex_push),
        .data_i  (ex_instr_d),
        .full_o  (ex_full),
        .pop_i   (ex_ready_i & ex_valid_o),
        .data_o  (ex_instr_o),
        .valid_o (ex_valid_o)
    );

    issue_fifo #(.payload_t(mem_instr_t)) u_mem_fifo (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .push_i  (mem_push),
        .data_i  (mem_instr_d),
        .full_o  (mem_full),
        .pop_i   (mem_ready_i & mem_valid_o),
        .data_o  (mem_instr_o),
        .valid_o (mem_valid_o)
    );

    // Nothing waiting and nothing queued
    assign idle_o = ~in_valid_i & ~ex_valid_o & ~mem_valid_o;

endmodule

// File: vec_remap_vectors.txt
// op funct dst src1 src2 reconf maxvl data1 | exp: dst src1 src2 lock dst_iszero mem_copy
// All hex, op 0 is load, 2 is store, anything else arithmetic
1 01 03 05 06 0 000 11110000 00 05 06 0 0 0
1 02 05 03 05 0 000 11110001 01 00 01 0 0 0
4 03 07 07 09 0 000 11110002 02 02 09 0 0 0
7 04 03 05 0c 0 000 11110003 00 01 0c 0 0 0
0 05 0a 03 07 0 000 20000004 03 00 02 1 0 1
2 06 0b 0a 05 0 000 20000005 04 03 01 1 1 1
1 3f 01 02 03 1 020 00000000 01 02 03 0 0 0
1 07 03 05 0a 0 020 30000007 00 05 0a 0 0 0
1 08 04 03 0b 0 020 30000008 04 00 0b 0 0 0
5 09 06 01 02 0 020 30000009 08 01 02 0 0 0
0 0a 09 04 06 0 020 4000000a 0c 04 08 1 0 1
2 0b 0d 09 0d 0 020 4000000b 10 0c 10 1 1 1
1 0c 0e 00 00 0 020 3000000c 14 00 00 0 0 0
1 0d 0f 0f 0e 0 020 3000000d 18 18 14 0 0 0
1 0e 10 03 04 0 020 3000000e 1c 00 04 0 0 0
1 0f 11 10 1f 0 020 3000000f 00 1c 1f 0 0 0
0 10 03 11 09 0 020 40000010 00 00 0c 1 0 1
1 3f 00 00 00 1 040 00000000 00 00 00 0 0 0
1 11 03 04 09 0 040 50000012 00 04 09 0 0 0
2 12 14 03 11 0 040 60000013 08 00 11 1 1 1
0 13 15 14 15 0 040 60000014 10 08 10 1 0 1
1 14 16 15 03 0 040 50000015 18 10 00 0 0 0
1 15 17 16 17 0 040 50000016 00 18 00 0 0 0

// File: vlog.f
+incdir+.
vrrm_pkg.sv
vrat.sv
vreg_alloc.sv
vrrm.sv
issue_fifo.sv
vec_remap_top.sv
tb_clkgen.sv
tb_vec_remap.sv

// File: vrat.sv
// Vector register alias table
// One write port, three combinational read ports, a valid bit per entry
`timescale 1ns/10ps
`include "vrrm_cfg.svh"

module vrat import vrrm_pkg::*; (
    input  logic      clk_i,
    input  logic      rstn_i,
    input  logic      clear_i,
    // Write port
    input  logic      wr_en_i,
    input  vreg_idx_t wr_addr_i,
    input  vreg_idx_t wr_data_i,
    // Read port 1
    input  vreg_idx_t rd_addr_1_i,
    output vreg_idx_t rd_data_1_o,
    output logic      rd_mapped_1_o,
    // Read port 2
    input  vreg_idx_t rd_addr_2_i,
    output vreg_idx_t rd_data_2_o,
    output logic      rd_mapped_2_o,
    // Read port 3
    input  vreg_idx_t rd_addr_3_i,
    output vreg_idx_t rd_data_3_o,
    output logic      rd_mapped_3_o
);

    vreg_idx_t              map_q [`VRRM_VREGS];
    logic [`VRRM_VREGS-1:0] valid_q;

    // Valid bits, a clear wipes every mapping at once
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q <= '0;
        end else if (clear_i) begin
            valid_q <= '0;
        end else if (wr_en_i) begin
            valid_q[wr_addr_i] <= 1'b1;
        end
    end

    // Mapping storage, only meaningful where the valid bit is set
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            map_q[wr_addr_i] <= wr_data_i;
        end
    end

    // Raw reads, the caller picks the identity when unmapped
    assign rd_data_1_o   = map_q[rd_addr_1_i];
    assign rd_mapped_1_o = valid_q[rd_addr_1_i];

    assign rd_data_2_o   = map_q[rd_addr_2_i];
    assign rd_mapped_2_o = valid_q[rd_addr_2_i];

    assign rd_data_3_o   = map_q[rd_addr_3_i];
    assign rd_mapped_3_o = valid_q[rd_addr_3_i];

    // The remap stage never renames and reconfigures in one instruction
    a_clear_wr_excl: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        !(clear_i && wr_en_i)
    ) else $error("vrat: clear and write in the same cycle");

endmodule

// File: vreg_alloc.sv
// Bump allocator for physical vector register groups
// Pointer advances by the group stride, stride reloads on restart
`timescale 1ns/10ps
`include "vrrm_cfg.svh"

module vreg_alloc import vrrm_pkg::*; (
    input  logic      clk_i,
    input  logic      rstn_i,
    input  logic      alloc_i,
    input  logic      restart_i,
    input  maxvl_t    maxvl_i,
    output vreg_idx_t next_vreg_o
);

    localparam int LANE_SHIFT = $clog2(`VRRM_LANES);
    localparam int STRIDE_W   = MAXVL_W - LANE_SHIFT;
    localparam int SUM_W      = ((STRIDE_W > VREG_IDX_W) ? STRIDE_W : VREG_IDX_W) + 1;

    vreg_idx_t           ptr_q;
    logic [STRIDE_W-1:0] stride_q;
    logic [SUM_W-1:0]    ptr_sum;

    // Wraps modulo the register count by dropping the upper bits
    assign ptr_sum = SUM_W'(ptr_q) + SUM_W'(stride_q);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ptr_q    <= '0;
            stride_q <= {{(STRIDE_W-1){1'b0}}, 1'b1};
        end else if (restart_i) begin
            ptr_q    <= '0;
            // Registers per group is maxvl over the lane count
            stride_q <= maxvl_i[MAXVL_W-1:LANE_SHIFT];
        end else if (alloc_i) begin
            ptr_q <= ptr_sum[VREG_IDX_W-1:0];
        end
    end

    assign next_vreg_o = ptr_q;

    // A zero stride would hand the same group to every destination
    a_stride_nonzero: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        restart_i |=> (stride_q != '0)
    ) else $error("vreg_alloc: reconfigure loaded a zero stride");

endmodule

// File: vrrm.sv
// Vector register remap stage
// Classifies, gates acceptance, renames dst and translates sources
`timescale 1ns/10ps

module vrrm import vrrm_pkg::*; (
    input  logic            clk_i,
    input  logic            rstn_i,
    // From the instruction queue
    input  logic            in_valid_i,
    input  v_instr_t        in_instr_i,
    output logic            in_pop_o,
    // Execute queue
    input  logic            ex_full_i,
    output logic            ex_push_o,
    output remapped_instr_t ex_instr_o,
    // Memory queue
    input  logic            mem_full_i,
    output logic            mem_push_o,
    output mem_instr_t      mem_instr_o
);

    logic      is_load;
    logic      is_store;
    logic      is_mem;
    logic      is_reconf;
    logic      accept;

    vreg_idx_t dst_map;
    logic      dst_mapped;
    vreg_idx_t src1_map;
    logic      src1_mapped;
    vreg_idx_t src2_map;
    logic      src2_mapped;
    vreg_idx_t alloc_vreg;

    vreg_idx_t out_dst;
    vreg_idx_t out_src1;
    vreg_idx_t out_src2;

    logic      tbl_wr;
    logic      tbl_clear;

    assign is_load   = (in_instr_i.op_class == OP_LOAD);
    assign is_store  = (in_instr_i.op_class == OP_STORE);
    assign is_mem    = is_load | is_store;
    assign is_reconf = in_instr_i.reconfigure;

    // Loads and stores need room in both queues
    assign accept     = in_valid_i & ~ex_full_i & (~is_mem | ~mem_full_i);
    assign in_pop_o   = accept;
    assign ex_push_o  = accept;
    assign mem_push_o = accept & is_mem;

    // Table and allocator only move on an accepted instruction
    assign tbl_wr    = accept & ~is_reconf & ~dst_mapped;
    assign tbl_clear = accept & is_reconf;

    // Reconfigures keep their architectural registers
    always_comb begin
        if (is_reconf) begin
            out_dst  = in_instr_i.dst;
            out_src1 = in_instr_i.src1;
            out_src2 = in_instr_i.src2;
        end else begin
            out_dst  = dst_mapped ? dst_map : alloc_vreg;
            // A source that names the dst follows the dst rename
            if (in_instr_i.src1 == in_instr_i.dst) begin
                out_src1 = out_dst;
            end else begin
                out_src1 = src1_mapped ? src1_map : in_instr_i.src1;
            end
            if (in_instr_i.src2 == in_instr_i.dst) begin
                out_src2 = out_dst;
            end else begin
                out_src2 = src2_mapped ? src2_map : in_instr_i.src2;
            end
        end
    end

    always_comb begin
        ex_instr_o.op_class    = in_instr_i.op_class;
        ex_instr_o.funct       = in_instr_i.funct;
        ex_instr_o.dst         = out_dst;
        ex_instr_o.src1        = out_src1;
        ex_instr_o.src2        = out_src2;
        ex_instr_o.reconfigure = is_reconf;
        ex_instr_o.maxvl       = in_instr_i.maxvl;
        ex_instr_o.data1       = in_instr_i.data1;
        ex_instr_o.dst_iszero  = is_store;
        ex_instr_o.lock        = is_mem & ~is_reconf;
    end

    always_comb begin
        mem_instr_o.op_class    = in_instr_i.op_class;
        mem_instr_o.dst         = out_dst;
        mem_instr_o.src1        = out_src1;
        mem_instr_o.src2        = out_src2;
        mem_instr_o.data1       = in_instr_i.data1;
        mem_instr_o.maxvl       = in_instr_i.maxvl;
        mem_instr_o.reconfigure = is_reconf;
    end

    vrat u_vrat (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .clear_i       (tbl_clear),
        .wr_en_i       (tbl_wr),
        .wr_addr_i     (in_instr_i.dst),
        .wr_data_i     (alloc_vreg),
        .rd_addr_1_i   (in_instr_i.dst),
        .rd_data_1_o   (dst_map),
        .rd_mapped_1_o (dst_mapped),
        .rd_addr_2_i   (in_instr_i.src1),
        .rd_data_2_o   (src1_map),
        .rd_mapped_2_o (src1_mapped),
        .rd_addr_3_i   (in_instr_i.src2),
        .rd_data_3_o   (src2_map),
        .rd_mapped_3_o (src2_mapped)
    );

    vreg_alloc u_vreg_alloc (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .alloc_i     (tbl_wr),
        .restart_i   (tbl_clear),
        .maxvl_i     (in_instr_i.maxvl),
        .next_vreg_o (alloc_vreg)
    );

endmodule

// File: vrrm_cfg.svh
// Configuration defines for the vector register remap stage
// Register file size, lane count, issue queue depth and scalar width
`ifndef VRRM_CFG_SVH
`define VRRM_CFG_SVH

// Architectural and physical vector registers
// Must be a power of two, the allocator wraps by truncation
`define VRRM_VREGS 32

// Vector lanes, sets the group stride divisor
`define VRRM_LANES 8

// Entries in each issue queue
`define VRRM_QDEPTH 4

// Scalar operand carried with each instruction
`define VRRM_DATA_W 32

`endif

// File: vrrm_pkg.sv
// Types for the vector register remap stage
// Opcode class, register index and the three instruction formats
`include "vrrm_cfg.svh"

package vrrm_pkg;

    localparam int VREG_IDX_W = $clog2(`VRRM_VREGS);
    localparam int MAXVL_W    = 9;
    localparam int FUNCT_W    = 6;

    typedef logic [VREG_IDX_W-1:0]   vreg_idx_t;
    typedef logic [MAXVL_W-1:0]      maxvl_t;
    typedef logic [FUNCT_W-1:0]      funct_t;
    typedef logic [`VRRM_DATA_W-1:0] data_t;

    // Opcode class, anything other than load or store is arithmetic
    typedef logic [2:0] op_class_t;
    localparam op_class_t OP_LOAD  = 3'b000;
    localparam op_class_t OP_STORE = 3'b010;

    // Instruction as it leaves the vector instruction queue
    typedef struct packed {
        op_class_t op_class;
        funct_t    funct;
        vreg_idx_t dst;
        vreg_idx_t src1;
        vreg_idx_t src2;
        logic      reconfigure;
        maxvl_t    maxvl;
        data_t     data1;
    } v_instr_t;

    // Execute side, registers already renamed
    typedef struct packed {
        op_class_t op_class;
        funct_t    funct;
        vreg_idx_t dst;
        vreg_idx_t src1;
        vreg_idx_t src2;
        logic      reconfigure;
        maxvl_t    maxvl;
        data_t     data1;
        logic      dst_iszero;  // stores write no register
        logic      lock;        // waits for the memory side
    } remapped_instr_t;

    // Memory side copy of loads and stores
    typedef struct packed {
        op_class_t op_class;
        vreg_idx_t dst;
        vreg_idx_t src1;
        vreg_idx_t src2;
        data_t     data1;
        maxvl_t    maxvl;
        logic      reconfigure;
    } mem_instr_t;

endpackage
